//--- common/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry
`define ICACHE_WAYS 2
`define ICACHE_SETS 16

// 32-bit beats per line
`define ICACHE_BEATS 4

// address split: tag | index | byte offset in line
`define ICACHE_OFFSET_BITS 4
`define ICACHE_INDEX_BITS 4
`define ICACHE_TAG_BITS 24

`endif

//--- common/icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

	typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;
	typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;
	typedef logic [$clog2(`ICACHE_BEATS)-1:0] offset_t;
	typedef logic [`ICACHE_WAYS-1:0] way_vec_t;
	typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_idx_t;

	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR  = 2'b01,
		BURST_WRAP  = 2'b10
	} burst_t;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_ARREADY,
		RECEIVING,
		DRAIN,
		FINISH
	} ctrl_state_t;

	typedef struct packed {
		logic        read;
		logic        flush;
		logic        stall_req;
		logic [31:0] address;
	} fetch_req_t;

	typedef struct packed {
		logic        stall;
		logic        valid;
		logic [31:0] rddata;
	} fetch_resp_t;

	// control half of the fetch response
	typedef struct packed {
		logic stall;
		logic valid;
	} fetch_ctl_t;

	typedef struct packed {
		logic        arvalid;
		logic [31:0] araddr;
		logic [7:0]  arlen;
		logic [2:0]  arsize;
		burst_t      arburst;
		logic        rready;
	} bus_req_t;

	typedef struct packed {
		logic        arready;
		logic        rvalid;
		logic        rlast;
		logic [31:0] rdata;
	} bus_resp_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
	} tag_entry_t;

	typedef logic [`ICACHE_BEATS-1:0][31:0] line_t;

	function automatic index_t addr_index(input logic [31:0] addr);
		return addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
	endfunction

	function automatic tag_t addr_tag(input logic [31:0] addr);
		return addr[31 -: `ICACHE_TAG_BITS];
	endfunction

	// word within the line
	function automatic offset_t addr_offset(input logic [31:0] addr);
		return addr[`ICACHE_OFFSET_BITS-1:2];
	endfunction

endpackage

`default_nettype wire

//--- design/lfsr_8bits.sv
`timescale 1ns/1ps
`default_nettype none

module lfsr_8bits (
	input  logic       clk,
	input  logic       rst,
	input  logic       update,
	output logic [7:0] val
);

	logic feedback;

	// x^8 + x^6 + x^5 + x^4 + 1, mirrored for a right shift
	assign feedback = val[0] ^ val[2] ^ val[3] ^ val[4];

	always_ff @(posedge clk) begin
		if (rst) begin
			// alternating seed, so the first fills go to alternate ways
			val <= 8'haa;
		end else if (update) begin
			val <= {feedback, val[7:1]};
		end
	end

endmodule

`default_nettype wire

//--- icache/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_tag_array (
	input  logic                 clk,
	input  logic                 rst,
	input  icache_pkg::index_t   index,
	input  icache_pkg::way_vec_t we,
	input  icache_pkg::tag_t     wtag,
	input  icache_pkg::tag_t     lookup_tag,
	output icache_pkg::way_vec_t hit
);
	import icache_pkg::*;

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_way
		tag_entry_t mem [`ICACHE_SETS];
		tag_entry_t rd_entry;

		always_ff @(posedge clk) begin
			if (rst) begin
				for (int s = 0; s < `ICACHE_SETS; s++) begin
					mem[s] <= '0;
				end
				rd_entry <= '0;
			end else begin
				if (we[w]) begin
					mem[index] <= '{valid: 1'b1, tag: wtag};
				end
				// read-first, a fill shows up on the next read
				rd_entry <= mem[index];
			end
		end

		assign hit[w] = rd_entry.valid && (rd_entry.tag == lookup_tag);
	end

endmodule

`default_nettype wire

//--- icache/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_data_array (
	input  logic                 clk,
	input  logic                 rst,
	input  icache_pkg::index_t   index,
	input  icache_pkg::way_vec_t we,
	input  icache_pkg::line_t    wline,
	input  icache_pkg::way_vec_t hit,
	input  icache_pkg::offset_t  offset,
	input  logic                 stall_req,
	output logic [31:0]          rddata
);
	import icache_pkg::*;

	logic [`ICACHE_WAYS-1:0][31:0] way_word;
	logic [31:0]                   sel_word;

	for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_way
		line_t mem [`ICACHE_SETS];
		line_t rd_line;

		always_ff @(posedge clk) begin
			if (we[w]) begin
				mem[index] <= wline;
			end
			rd_line <= mem[index];
		end

		assign way_word[w] = rd_line[offset];
	end

	// at most one way hits
	always_comb begin
		sel_word = '0;
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			if (hit[w]) begin
				sel_word |= way_word[w];
			end
		end
	end

	// stage 3
	always_ff @(posedge clk) begin
		if (rst) begin
			rddata <= '0;
		end else if (!stall_req) begin
			rddata <= sel_word;
		end
	end

endmodule

`default_nettype wire

//--- icache/icache_refill_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module icache_refill_buffer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  icache_pkg::bus_resp_t bus_resp,
	input  logic                  rready,
	output icache_pkg::line_t     line,
	output logic                  line_done
);
	import icache_pkg::*;

	offset_t beat;
	line_t   buffer;
	logic    take;

	assign take      = bus_resp.rvalid & rready;
	assign line_done = take & bus_resp.rlast;

	always_ff @(posedge clk) begin
		if (rst || start) begin
			beat <= '0;
		end else if (take) begin
			beat <= beat + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			buffer[beat] <= bus_resp.rdata;
		end
	end

	// current beat goes straight through so the line is whole on rlast
	always_comb begin
		line = buffer;
		if (take) begin
			line[beat] = bus_resp.rdata;
		end
	end

endmodule

`default_nettype wire

//--- icache/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  icache_pkg::fetch_req_t req,
	output icache_pkg::fetch_ctl_t resp_ctl,
	input  icache_pkg::way_vec_t   hit,
	input  logic                   line_done,
	input  icache_pkg::bus_resp_t  bus_resp,
	output icache_pkg::bus_req_t   bus_req,
	output icache_pkg::index_t     ram_index,
	output icache_pkg::way_vec_t   tag_we,
	output icache_pkg::way_vec_t   data_we,
	output icache_pkg::tag_t       install_tag,
	output icache_pkg::offset_t    offset,
	input  icache_pkg::way_idx_t   victim,
	output logic                   lfsr_update,
	output logic                   refill_start
);
	import icache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_d;
	logic [31:0] s2_addr;
	logic        s2_read;
	logic [31:0] refill_addr;
	logic        ar_done;
	logic        valid_q;
	logic        busy;
	logic        any_hit;
	logic        stall;
	logic        stall_s2;
	logic        ar_fire;
	logic        install;

	assign any_hit = |hit;
	assign busy    = (state != IDLE);

	// miss or refill in progress holds stage 2, unless flushed or held by the cpu
	assign stall    = s2_read & ~req.flush & ~req.stall_req & (busy | ~any_hit);
	assign stall_s2 = stall | req.stall_req;

	assign resp_ctl.stall = stall;
	assign resp_ctl.valid = valid_q;

	// held stage 2 keeps re-reading its own set
	assign ram_index   = stall_s2 ? addr_index(s2_addr) : addr_index(req.address);
	assign install_tag = addr_tag(s2_addr);
	assign offset      = addr_offset(s2_addr);

	// read address channel, line aligned INCR burst of 4-byte beats
	assign bus_req.arvalid = (state == WAIT_ARREADY) | ((state == DRAIN) & ~ar_done);
	assign bus_req.araddr  = {refill_addr[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}};
	assign bus_req.arlen   = 8'(`ICACHE_BEATS - 1);
	assign bus_req.arsize  = 3'b010;
	assign bus_req.arburst = BURST_INCR;
	assign bus_req.rready  = (state == RECEIVING) | (state == DRAIN);

	assign ar_fire      = bus_req.arvalid & bus_resp.arready;
	assign refill_start = ar_fire;

	// install on the last beat unless the request got flushed
	assign install     = (state == RECEIVING) & line_done & ~req.flush;
	assign lfsr_update = install;

	always_comb begin
		tag_we         = '0;
		tag_we[victim] = install;
	end

	assign data_we = tag_we;

	always_comb begin
		state_d = state;
		case (state)
			IDLE: begin
				if (s2_read & ~any_hit & ~req.flush) begin
					state_d = WAIT_ARREADY;
				end
			end
			WAIT_ARREADY: begin
				if (req.flush) begin
					state_d = DRAIN;
				end else if (bus_resp.arready) begin
					state_d = RECEIVING;
				end
			end
			RECEIVING: begin
				if (line_done) begin
					state_d = req.flush ? IDLE : FINISH;
				end else if (req.flush) begin
					state_d = DRAIN;
				end
			end
			DRAIN: begin
				if (line_done) begin
					state_d = IDLE;
				end
			end
			// one more cycle so the RAMs re-read the new line
			FINISH: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= IDLE;
			s2_read <= 1'b0;
			valid_q <= 1'b0;
			ar_done <= 1'b0;
		end else begin
			state <= state_d;
			if (!stall_s2) begin
				s2_read <= req.read;
			end else if (req.flush) begin
				s2_read <= 1'b0;
			end
			if (!req.stall_req) begin
				valid_q <= s2_read & ~req.flush & ~busy & any_hit;
			end
			if (state == IDLE) begin
				ar_done <= 1'b0;
			end else if (ar_fire) begin
				ar_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_s2) begin
			s2_addr <= req.address;
		end
		// stays put while a refill runs, even if stage 2 moves on
		if (state == IDLE) begin
			refill_addr <= s2_addr;
		end
	end

endmodule

`default_nettype wire

//--- design/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_top (
	input  logic                    clk,
	input  logic                    rst,
	input  icache_pkg::fetch_req_t  fetch_req,
	output icache_pkg::fetch_resp_t fetch_resp,
	output icache_pkg::bus_req_t    bus_req,
	input  icache_pkg::bus_resp_t   bus_resp
);
	import icache_pkg::*;

	fetch_ctl_t  resp_ctl;
	way_vec_t    hit;
	way_vec_t    tag_we;
	way_vec_t    data_we;
	index_t      ram_index;
	tag_t        install_tag;
	offset_t     offset;
	line_t       refill_line;
	logic        line_done;
	logic        lfsr_update;
	logic        refill_start;
	logic [7:0]  lfsr_val;
	logic [31:0] rddata;

	assign fetch_resp.stall  = resp_ctl.stall;
	assign fetch_resp.valid  = resp_ctl.valid;
	assign fetch_resp.rddata = rddata;

	icache_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.req          (fetch_req),
		.resp_ctl     (resp_ctl),
		.hit          (hit),
		.line_done    (line_done),
		.bus_resp     (bus_resp),
		.bus_req      (bus_req),
		.ram_index    (ram_index),
		.tag_we       (tag_we),
		.data_we      (data_we),
		.install_tag  (install_tag),
		.offset       (offset),
		.victim       (lfsr_val[$clog2(`ICACHE_WAYS)-1:0]),
		.lfsr_update  (lfsr_update),
		.refill_start (refill_start)
	);

	icache_tag_array u_tag_array (
		.clk        (clk),
		.rst        (rst),
		.index      (ram_index),
		.we         (tag_we),
		.wtag       (install_tag),
		.lookup_tag (install_tag),
		.hit        (hit)
	);

	icache_data_array u_data_array (
		.clk       (clk),
		.rst       (rst),
		.index     (ram_index),
		.we        (data_we),
		.wline     (refill_line),
		.hit       (hit),
		.offset    (offset),
		.stall_req (fetch_req.stall_req),
		.rddata    (rddata)
	);

	icache_refill_buffer u_refill_buffer (
		.clk       (clk),
		.rst       (rst),
		.start     (refill_start),
		.bus_resp  (bus_resp),
		.rready    (bus_req.rready),
		.line      (refill_line),
		.line_done (line_done)
	);

	lfsr_8bits u_lfsr (
		.clk    (clk),
		.rst    (rst),
		.update (lfsr_update),
		.val    (lfsr_val)
	);

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk,
	output logic rst
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// synchronous reset over the first 8 rising edges
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- testbench/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
	input  logic                  clk,
	input  logic                  rst,
	input  icache_pkg::bus_req_t  bus_req,
	output icache_pkg::bus_resp_t bus_resp
);
	import icache_pkg::*;

	integer seed;

	function automatic logic [31:0] word_at(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
	endfunction

	// one read burst, started on a falling edge with arvalid high
	task automatic serve_burst();
		int          delay;
		int          beats;
		logic [31:0] addr;
		delay = $unsigned($random(seed)) % 4;
		repeat (delay) @(negedge clk);
		addr  = {bus_req.araddr[31:2], 2'b00};
		beats = int'(bus_req.arlen) + 1;
		bus_resp.arready = 1'b1;
		// arvalid is held, so the address is taken on the next rising edge
		@(negedge clk);
		bus_resp.arready = 1'b0;
		for (int b = 0; b < beats; b++) begin
			bus_resp.rvalid = 1'b1;
			bus_resp.rlast  = (b == beats - 1);
			bus_resp.rdata  = word_at(addr + 32'(4 * b));
			// beat only moves with rready high
			while (!bus_req.rready) begin
				@(negedge clk);
			end
			@(negedge clk);
		end
		bus_resp.rvalid = 1'b0;
		bus_resp.rlast  = 1'b0;
		bus_resp.rdata  = '0;
	endtask

	initial begin
		seed     = 32'he499ec03;
		bus_resp = '0;
		forever begin
			@(negedge clk);
			if (!rst && bus_req.arvalid) begin
				serve_burst();
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/icache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_settings.svh"

module icache_tb;
	import icache_pkg::*;

	typedef struct packed {
		logic [31:0] addr;
		logic        flush;
		logic [3:0]  stall_cycles;
		logic [31:0] word;
		logic [7:0]  bursts;
	} entry_t;

	logic        clk;
	logic        rst;
	fetch_req_t  fetch_req;
	fetch_resp_t fetch_resp;
	bus_req_t    bus_req;
	bus_resp_t   bus_resp;

	entry_t      entries[$];
	logic [31:0] cur_addr = '0;
	logic [7:0]  bursts = '0;
	int          errors = 0;
	int          cycles = 0;
	int          timeout_cycles;

	clock_gen clk_gen (
		.clk (clk),
		.rst (rst)
	);

	icache_top dut (
		.clk        (clk),
		.rst        (rst),
		.fetch_req  (fetch_req),
		.fetch_resp (fetch_resp),
		.bus_req    (bus_req),
		.bus_resp   (bus_resp)
	);

	axi_mem_model mem (
		.clk      (clk),
		.rst      (rst),
		.bus_req  (bus_req),
		.bus_resp (bus_resp)
	);

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at time %0t: %s, got %h, expected %h",
				$time, what, actual, expected);
			$display("ERRORS FOUND");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// memory word is its own address xor a fixed pattern
	function automatic logic [31:0] expected_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h5a5a0000;
	endfunction

	task automatic add_entry(input logic [31:0] addr, input logic flush,
			input logic [3:0] stall_cycles, input logic [7:0] total_bursts);
		entry_t e;
		e.addr         = addr;
		e.flush        = flush;
		e.stall_cycles = stall_cycles;
		e.word         = expected_word(addr);
		e.bursts       = total_bursts;
		entries.push_back(e);
	endtask

	// starts and ends on a falling edge
	task automatic apply_entry(input entry_t e, input logic [7:0] bursts_before);
		int   waited;
		logic miss;
		miss = (e.bursts != bursts_before);
		check_value(32'(fetch_resp.stall), 32'd0, "stall low before a request");
		cur_addr          = e.addr;
		fetch_req.read    = 1'b1;
		fetch_req.address = e.addr;
		@(negedge clk);
		check_value(32'(fetch_resp.stall), 32'(miss), "stall with the request in stage 2");
		fetch_req.read    = 1'b0;
		// stage 2 moves on to the neighbouring word, whose data differs
		fetch_req.address = e.addr ^ 32'h4;
		if (e.flush) begin
			@(negedge clk);
			check_value(32'(bus_req.arvalid), 32'd1, "refill pending before flush");
			fetch_req.flush = 1'b1;
			@(negedge clk);
			fetch_req.flush = 1'b0;
			repeat (2) begin
				check_value(32'(fetch_resp.valid), 32'd0, "valid for a flushed request");
				@(negedge clk);
			end
			// drained burst must finish before the next request
			while (bus_req.arvalid || bus_req.rready) begin
				check_value(32'(fetch_resp.valid), 32'd0, "valid during drain");
				@(negedge clk);
			end
		end else begin
			waited = 1;
			while (!fetch_resp.valid) begin
				@(negedge clk);
				waited++;
			end
			if (!miss) begin
				check_value(32'(waited), 32'd2, "hit latency in cycles");
			end
			check_value(fetch_resp.rddata, e.word, "read data");
			if (e.stall_cycles != 0) begin
				fetch_req.stall_req = 1'b1;
				repeat (e.stall_cycles) begin
					@(negedge clk);
					check_value(32'(fetch_resp.valid), 32'd1, "valid held by stall_req");
					check_value(fetch_resp.rddata, e.word, "read data held by stall_req");
				end
				fetch_req.stall_req = 1'b0;
			end
			@(negedge clk);
			check_value(32'(fetch_resp.valid), 32'd0, "valid lasts one cycle");
		end
		check_value(32'(bursts), 32'(e.bursts), "burst count");
	endtask

	// count address handshakes and check each burst request
	always @(posedge clk) begin
		if (!rst && bus_req.arvalid && bus_resp.arready) begin
			bursts <= bursts + 8'd1;
			check_value(bus_req.araddr,
				{cur_addr[31:`ICACHE_OFFSET_BITS], {`ICACHE_OFFSET_BITS{1'b0}}},
				"line aligned araddr");
			check_value(32'(bus_req.arlen), `ICACHE_BEATS - 1, "arlen");
			check_value(32'(bus_req.arsize), 32'd2, "arsize");
			check_value(32'(bus_req.arburst), 32'd1, "arburst");
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: the run went past %0d cycles", timeout_cycles);
			$display("ERRORS FOUND");
			$fatal(1, "cache did not answer in time");
		end
	end

	initial begin
		logic [7:0] prev_bursts;
		fetch_req = '0;
		// lines 0x1000, 0xabc000, 0x1200000 share set 0
		add_entry(32'h0000_1004, 1'b0, 4'd0, 8'd1);
		add_entry(32'h0000_100c, 1'b0, 4'd0, 8'd1);
		add_entry(32'h0000_1000, 1'b0, 4'd0, 8'd1);
		add_entry(32'h00ab_c008, 1'b0, 4'd0, 8'd2);
		add_entry(32'h0000_1008, 1'b0, 4'd0, 8'd2);
		add_entry(32'h00ab_c004, 1'b0, 4'd0, 8'd2);
		add_entry(32'h0000_1004, 1'b0, 4'd0, 8'd2);
		add_entry(32'h00ab_c00c, 1'b0, 4'd3, 8'd2);
		add_entry(32'h0120_0000, 1'b0, 4'd0, 8'd3);
		// flushed refill still drains, so it counts as a burst
		add_entry(32'h0000_4050, 1'b1, 4'd0, 8'd4);
		add_entry(32'h0000_4054, 1'b0, 4'd0, 8'd5);
		add_entry(32'h0000_4058, 1'b0, 4'd4, 8'd5);
		add_entry(32'h0000_405c, 1'b0, 4'd0, 8'd5);
		add_entry(32'hfff0_7ff0, 1'b0, 4'd2, 8'd6);
		add_entry(32'hfff0_7ffc, 1'b0, 4'd0, 8'd6);
		timeout_cycles = entries.size() * 40;
		prev_bursts    = '0;
		@(negedge clk);
		while (rst) begin
			@(negedge clk);
		end
		check_value(32'(fetch_resp.stall), 32'd0, "stall after reset");
		check_value(32'(fetch_resp.valid), 32'd0, "valid after reset");
		check_value(32'(bus_req.arvalid), 32'd0, "arvalid after reset");
		check_value(32'(bus_req.rready), 32'd0, "rready after reset");
		for (int i = 0; i < entries.size(); i++) begin
			apply_entry(entries[i], prev_bursts);
			prev_bursts = entries[i].bursts;
		end
		if (errors == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("ERRORS FOUND");
			$fatal(1, "checks failed");
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/icache_pkg.sv
design/lfsr_8bits.sv
icache/icache_tag_array.sv
icache/icache_data_array.sv
icache/icache_refill_buffer.sv
icache/icache_ctrl.sv
design/icache_top.sv
testbench/clock_gen.sv
testbench/axi_mem_model.sv
testbench/icache_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run; exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module icache_tb \
	-f tb.f --Mdir obj_dir -o icache_tb &&
./obj_dir/icache_tb ||
{ echo "simulation failed"; exit 1; }
